// File: rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

`define RV_XLEN      32
`define RV_REGS      32
`define RV_REG_BITS  5
`define RV_RESET_PC  32'h0000_0000

// Major opcodes kept by this core.
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LUI    7'b0110111

`define RV_F3_ADD    3'b000
`define RV_F3_XOR    3'b100
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111
`define RV_F7_SUB    7'b0100000

`endif

// File: rv_core_pkg.sv
`include "rv_core_params.svh"

package rv_core_pkg;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [`RV_REG_BITS-1:0] rs2;
        logic [`RV_REG_BITS-1:0] rs1;
        logic [2:0]              funct3;
        logic [`RV_REG_BITS-1:0] rd;
        logic [6:0]              opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]             imm12;
        logic [`RV_REG_BITS-1:0] rs1;
        logic [2:0]              funct3;
        logic [`RV_REG_BITS-1:0] rd;
        logic [6:0]              opcode;
    } i_type_t;

    // One instruction word, seen either as R-type or as I-type.
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
    } inst_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        inst_t               inst;
    } fetch_t;

    typedef struct packed {
        logic                    valid;
        logic [`RV_XLEN-1:0]     pc;
        logic [`RV_REG_BITS-1:0] rd;
        alu_op_t                 alu_op;
        logic [`RV_XLEN-1:0]     operand_a;
        logic [`RV_XLEN-1:0]     operand_b;
    } issue_t;

    typedef struct packed {
        logic                    valid;
        logic [`RV_XLEN-1:0]     pc;
        logic [`RV_REG_BITS-1:0] rd;
        logic [`RV_XLEN-1:0]     value;
    } result_t;

endpackage

// File: rv_fetch.sv
`include "rv_core_params.svh"

module rv_fetch (
    input  logic                clock,
    input  logic                reset,
    input  logic                stall,
    input  logic                imem_ack,
    input  logic [`RV_XLEN-1:0] imem_data,
    output logic                imem_req,
    output logic [`RV_XLEN-1:0] imem_addr,
    output rv_core_pkg::fetch_t fetch
);
    import rv_core_pkg::*;

    typedef enum logic {
        fetch_wait,
        fetch_req
    } fetch_state_t;

    fetch_state_t        state;
    logic [`RV_XLEN-1:0] pc;
    logic                held_valid;
    logic [`RV_XLEN-1:0] held_pc;
    inst_t               held_inst;
    logic                slot_free;
    logic                capture;

    // The holding slot frees up in the same cycle that decode takes its word.
    assign slot_free = !held_valid || !stall;
    assign capture   = (state == fetch_req) && imem_ack && slot_free;

    assign imem_req  = (state == fetch_req);
    assign imem_addr = pc;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= fetch_wait;
            pc         <= `RV_RESET_PC;
            held_valid <= 1'b0;
        end else begin
            case (state)
                // A new request waits until memory has dropped the last ack.
                fetch_wait: if (!imem_ack) state <= fetch_req;
                fetch_req:  if (capture) state <= fetch_wait;
                default:    state <= fetch_wait;
            endcase
            if (capture) begin
                pc         <= pc + `RV_XLEN'(4);
                held_valid <= 1'b1;
            end else if (!stall) begin
                held_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            held_pc   <= pc;
            held_inst <= imem_data;
        end
    end

    always_comb begin
        fetch.valid = held_valid;
        fetch.pc    = held_pc;
        fetch.inst  = held_inst;
    end

    // Once raised, the request is held until memory answers.
    assert property (@(posedge clock) disable iff (reset)
        (imem_req && !imem_ack) |=> imem_req)
        else $error("imem_req dropped before imem_ack rose");

endmodule

// File: rv_decode.sv
`include "rv_core_params.svh"

module rv_decode (
    input  rv_core_pkg::fetch_t     fetch,
    input  logic [`RV_XLEN-1:0]     rs1_data,
    input  logic [`RV_XLEN-1:0]     rs2_data,
    input  logic [`RV_REG_BITS-1:0] exe_rd,
    input  logic                    exe_valid,
    input  logic [`RV_REG_BITS-1:0] wb_rd,
    input  logic                    wb_valid,
    output logic [`RV_REG_BITS-1:0] rs1_addr,
    output logic [`RV_REG_BITS-1:0] rs2_addr,
    output logic                    stall,
    output rv_core_pkg::issue_t     issue
);
    import rv_core_pkg::*;

    inst_t               inst;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic                supported;
    logic                use_rs1;
    logic                use_rs2;
    alu_op_t             alu_op;
    logic [`RV_XLEN-1:0] operand_a;
    logic [`RV_XLEN-1:0] operand_b;
    logic                rs1_hit;
    logic                rs2_hit;

    assign inst     = fetch.inst;
    assign rs1_addr = inst.i_type.rs1;
    assign rs2_addr = inst.r_type.rs2;
    assign imm_i    = {{(`RV_XLEN-12){inst.i_type.imm12[11]}}, inst.i_type.imm12};
    // The LUI immediate occupies every bit above rd and opcode.
    assign imm_u    = {inst.r_type.funct7, inst.r_type.rs2, inst.r_type.rs1,
                       inst.r_type.funct3, 12'b0};

    always_comb begin
        supported = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        alu_op    = alu_pass_b;
        operand_a = '0;
        operand_b = '0;
        case (inst.r_type.opcode)
            `RV_OP_IMM: begin
                use_rs1   = 1'b1;
                operand_a = rs1_data;
                operand_b = imm_i;
                supported = 1'b1;
                case (inst.i_type.funct3)
                    `RV_F3_ADD: alu_op = alu_add;
                    `RV_F3_XOR: alu_op = alu_xor;
                    `RV_F3_OR:  alu_op = alu_or;
                    `RV_F3_AND: alu_op = alu_and;
                    default:    supported = 1'b0;
                endcase
            end
            `RV_OP_REG: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                operand_a = rs1_data;
                operand_b = rs2_data;
                supported = (inst.r_type.funct7 == 7'b0);
                case (inst.r_type.funct3)
                    `RV_F3_ADD: begin
                        if (inst.r_type.funct7 == `RV_F7_SUB) begin
                            alu_op    = alu_sub;
                            supported = 1'b1;
                        end else begin
                            alu_op = alu_add;
                        end
                    end
                    `RV_F3_XOR: alu_op = alu_xor;
                    `RV_F3_OR:  alu_op = alu_or;
                    `RV_F3_AND: alu_op = alu_and;
                    default:    supported = 1'b0;
                endcase
            end
            `RV_OP_LUI: begin
                operand_b = imm_u;
                supported = 1'b1;
            end
            default: supported = 1'b0;
        endcase
        // Anything else retires as a zero written to x0.
        if (!supported) begin
            use_rs1   = 1'b0;
            use_rs2   = 1'b0;
            alu_op    = alu_pass_b;
            operand_a = '0;
            operand_b = '0;
        end
    end

    assign rs1_hit = use_rs1 && (rs1_addr != '0) &&
                     ((exe_valid && exe_rd == rs1_addr) || (wb_valid && wb_rd == rs1_addr));
    assign rs2_hit = use_rs2 && (rs2_addr != '0) &&
                     ((exe_valid && exe_rd == rs2_addr) || (wb_valid && wb_rd == rs2_addr));
    assign stall   = fetch.valid && (rs1_hit || rs2_hit);

    always_comb begin
        issue.valid     = fetch.valid && !stall;
        issue.pc        = fetch.pc;
        issue.rd        = supported ? inst.r_type.rd : '0;
        issue.alu_op    = alu_op;
        issue.operand_a = operand_a;
        issue.operand_b = operand_b;
    end

endmodule

// File: rv_execute.sv
`include "rv_core_params.svh"

module rv_execute (
    input  logic                    clock,
    input  logic                    reset,
    input  rv_core_pkg::issue_t     issue,
    output logic [`RV_REG_BITS-1:0] exe_rd,
    output logic                    exe_valid,
    output rv_core_pkg::result_t    result
);
    import rv_core_pkg::*;

    issue_t              issue_q;
    logic [`RV_XLEN-1:0] alu_value;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            issue_q <= '0;
        end else begin
            issue_q <= issue;
        end
    end

    always_comb begin
        case (issue_q.alu_op)
            alu_add: alu_value = issue_q.operand_a + issue_q.operand_b;
            alu_sub: alu_value = issue_q.operand_a - issue_q.operand_b;
            alu_xor: alu_value = issue_q.operand_a ^ issue_q.operand_b;
            alu_or:  alu_value = issue_q.operand_a | issue_q.operand_b;
            alu_and: alu_value = issue_q.operand_a & issue_q.operand_b;
            default: alu_value = issue_q.operand_b;
        endcase
    end

    // Decode compares its sources against this held destination.
    assign exe_rd    = issue_q.rd;
    assign exe_valid = issue_q.valid;

    always_comb begin
        result.valid = issue_q.valid;
        result.pc    = issue_q.pc;
        result.rd    = issue_q.rd;
        result.value = alu_value;
    end

endmodule

// File: rv_writeback.sv
`include "rv_core_params.svh"

module rv_writeback (
    input  logic                    clock,
    input  logic                    reset,
    input  rv_core_pkg::result_t    result,
    input  logic [`RV_REG_BITS-1:0] rs1_addr,
    input  logic [`RV_REG_BITS-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]     rs1_data,
    output logic [`RV_XLEN-1:0]     rs2_data,
    output logic [`RV_REG_BITS-1:0] wb_rd,
    output logic                    wb_valid,
    output rv_core_pkg::result_t    retire
);
    import rv_core_pkg::*;

    result_t             result_q;
    logic [`RV_XLEN-1:0] regs [`RV_REGS];
    logic                reg_we;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_q <= '0;
        end else begin
            result_q <= result;
        end
    end

    // The held result reaches the register file on the edge that retires it.
    assign reg_we = result_q.valid && (result_q.rd != '0);

    always_ff @(posedge clock) begin
        if (reg_we) begin
            regs[result_q.rd] <= result_q.value;
        end
    end

    // Reads see the old value while the write is still pending, so decode
    // stalls on a match against the held rd.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    assign wb_rd    = result_q.rd;
    assign wb_valid = result_q.valid;
    assign retire   = result_q;

    assert property (@(posedge clock) disable iff (reset)
        regs[0] === $past(regs[0]))
        else $error("write to register x0");

endmodule

// File: rv_core.sv
`include "rv_core_params.svh"

module rv_core (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 imem_ack,
    input  logic [`RV_XLEN-1:0]  imem_data,
    output logic                 imem_req,
    output logic [`RV_XLEN-1:0]  imem_addr,
    output rv_core_pkg::result_t retire
);
    import rv_core_pkg::*;

    logic                    reset_meta;
    logic                    reset_sync;
    fetch_t                  fetch;
    issue_t                  issue;
    result_t                 result;
    logic                    stall;
    logic [`RV_REG_BITS-1:0] rs1_addr;
    logic [`RV_REG_BITS-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]     rs1_data;
    logic [`RV_XLEN-1:0]     rs2_data;
    logic [`RV_REG_BITS-1:0] exe_rd;
    logic                    exe_valid;
    logic [`RV_REG_BITS-1:0] wb_rd;
    logic                    wb_valid;

    // Reset asserts at once and releases two clock edges after the input drops.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            reset_meta <= 1'b1;
            reset_sync <= 1'b1;
        end else begin
            reset_meta <= 1'b0;
            reset_sync <= reset_meta;
        end
    end

    rv_fetch i_fetch (
        .clock     (clock),
        .reset     (reset_sync),
        .stall     (stall),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .fetch     (fetch)
    );

    rv_decode i_decode (
        .fetch     (fetch),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .exe_rd    (exe_rd),
        .exe_valid (exe_valid),
        .wb_rd     (wb_rd),
        .wb_valid  (wb_valid),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .stall     (stall),
        .issue     (issue)
    );

    rv_execute i_execute (
        .clock     (clock),
        .reset     (reset_sync),
        .issue     (issue),
        .exe_rd    (exe_rd),
        .exe_valid (exe_valid),
        .result    (result)
    );

    rv_writeback i_writeback (
        .clock     (clock),
        .reset     (reset_sync),
        .result    (result),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_rd     (wb_rd),
        .wb_valid  (wb_valid),
        .retire    (retire)
    );

endmodule

// File: tb_rv_core.sv
`include "rv_core_params.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_core_pkg::*;

    localparam int PROG_LEN       = 200;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 100;

    logic                clock;
    logic                reset;
    logic                imem_ack;
    logic [`RV_XLEN-1:0] imem_data;
    logic                imem_req;
    logic [`RV_XLEN-1:0] imem_addr;
    result_t             retire;

    logic [`RV_XLEN-1:0] program_mem [256];
    logic [`RV_XLEN-1:0] model_regs [`RV_REGS];
    logic [15:0]         lfsr_state;
    logic                pending;
    logic [31:0]         delay;
    int                  fetched;
    int                  retired;
    int                  cycles;

    rv_core i_dut (
        .clock     (clock),
        .reset     (reset),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .retire    (retire)
    );

    always #5 clock = ~clock;

    // Taps 16, 14, 13 and 11 give a maximal length sequence.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, `RV_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    // Registers x1 to x7 get a value before anything reads them.
    task automatic build_program();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        int          n;
        n = 0;
        for (int r = 1; r < 8; r++) begin
            take_bits(12, imm);
            program_mem[n] = enc_i(imm[11:0], 5'd0, `RV_F3_ADD, 5'(r));
            n++;
        end
        program_mem[n]     = enc_i(12'h123, 5'd1, `RV_F3_ADD, 5'd0);
        program_mem[n + 1] = enc_r(7'h00, 5'd1, 5'd0, `RV_F3_ADD, 5'd2);
        program_mem[n + 2] = enc_r(`RV_F7_SUB, 5'd1, 5'd0, `RV_F3_ADD, 5'd3);
        program_mem[n + 3] = enc_r(`RV_F7_SUB, 5'd2, 5'd3, `RV_F3_ADD, 5'd4);
        program_mem[n + 4] = enc_u(20'habcde, 5'd5);
        program_mem[n + 5] = enc_i(12'hfff, 5'd5, `RV_F3_ADD, 5'd5);
        program_mem[n + 6] = 32'h0000_2083;
        program_mem[n + 7] = enc_r(7'h00, 5'd0, 5'd1, `RV_F3_ADD, 5'd6);
        n = n + 8;
        while (n < PROG_LEN) begin
            take_bits(4, kind);
            take_bits(3, rd);
            take_bits(3, rs1);
            take_bits(3, rs2);
            take_bits(12, imm);
            case (kind[3:0])
                4'd0, 4'd1: program_mem[n] = enc_i(imm[11:0], rs1[4:0], `RV_F3_ADD, rd[4:0]);
                4'd2:       program_mem[n] = enc_i(imm[11:0], rs1[4:0], `RV_F3_XOR, rd[4:0]);
                4'd3:       program_mem[n] = enc_i(imm[11:0], rs1[4:0], `RV_F3_OR, rd[4:0]);
                4'd4:       program_mem[n] = enc_i(imm[11:0], rs1[4:0], `RV_F3_AND, rd[4:0]);
                4'd5:       program_mem[n] = enc_u({imm[11:0], rs2[2:0], rs1[2:0], kind[1:0]},
                                                   rd[4:0]);
                4'd6, 4'd7: program_mem[n] = enc_r(7'h00, rs2[4:0], rs1[4:0], `RV_F3_ADD, rd[4:0]);
                4'd8, 4'd9: program_mem[n] = enc_r(`RV_F7_SUB, rs2[4:0], rs1[4:0], `RV_F3_ADD,
                                                   rd[4:0]);
                4'd10:      program_mem[n] = enc_r(7'h00, rs2[4:0], rs1[4:0], `RV_F3_XOR, rd[4:0]);
                4'd11:      program_mem[n] = enc_r(7'h00, rs2[4:0], rs1[4:0], `RV_F3_OR, rd[4:0]);
                4'd12:      program_mem[n] = enc_r(7'h00, rs2[4:0], rs1[4:0], `RV_F3_AND, rd[4:0]);
                // A shift immediate and a branch stand for encodings outside the core.
                4'd13:      program_mem[n] = enc_i(imm[11:0], rs1[4:0], 3'b001, rd[4:0]);
                4'd14:      program_mem[n] = {imm[6:0], rs2[4:0], rs1[4:0], 3'b000, imm[11:7],
                                              7'b1100011};
                default:    program_mem[n] = enc_r(7'h00, rs2[4:0], rs1[4:0], `RV_F3_ADD, 5'd0);
            endcase
            n++;
        end
    endtask

    function automatic result_t expect_result(input logic [31:0] pc, input logic [31:0] word);
        result_t             res;
        logic [6:0]          opcode;
        logic [2:0]          funct3;
        logic [6:0]          funct7;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic                known;
        opcode    = word[6:0];
        funct3    = word[14:12];
        funct7    = word[31:25];
        a         = model_regs[word[19:15]];
        known     = 1'b1;
        res.valid = 1'b1;
        res.pc    = pc;
        res.rd    = word[11:7];
        res.value = '0;
        if (opcode == `RV_OP_IMM) begin
            b = {{(`RV_XLEN-12){word[31]}}, word[31:20]};
        end else begin
            b = model_regs[word[24:20]];
        end
        if (opcode == `RV_OP_LUI) begin
            res.value = {word[31:12], 12'h000};
        end else if (opcode == `RV_OP_IMM || (opcode == `RV_OP_REG && funct7 == 7'h00)) begin
            case (funct3)
                `RV_F3_ADD: res.value = a + b;
                `RV_F3_XOR: res.value = a ^ b;
                `RV_F3_OR:  res.value = a | b;
                `RV_F3_AND: res.value = a & b;
                default:    known = 1'b0;
            endcase
        end else if (opcode == `RV_OP_REG && funct7 == `RV_F7_SUB && funct3 == `RV_F3_ADD) begin
            res.value = a - b;
        end else begin
            known = 1'b0;
        end
        if (!known) begin
            res.rd    = '0;
            res.value = '0;
        end
        return res;
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        imem_ack   = 1'b0;
        imem_data  = '0;
        fetched    = 0;
        retired    = 0;
        cycles     = 0;
        pending    = 1'b0;
        delay      = '0;
        lfsr_state = 16'd4;
        for (int r = 0; r < `RV_REGS; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        repeat (3) @(posedge clock);
        @(negedge clock);
        compare("imem_req", 32'(imem_req), 32'd0);
        compare("retire.valid", 32'(retire.valid), 32'd0);
        reset = 1'b0;
    end

    // Memory answers after 0 to 3 cycles and stays silent past the program end.
    always @(negedge clock) begin
        if (reset) begin
            imem_ack = 1'b0;
            pending  = 1'b0;
        end else if (imem_ack) begin
            if (!imem_req) begin
                imem_ack = 1'b0;
            end
        end else if (imem_req && imem_addr < 32'(PROG_LEN * 4)) begin
            if (!pending) begin
                take_bits(2, delay);
                pending = 1'b1;
            end
            if (delay == 32'd0) begin
                compare("imem_addr", imem_addr, `RV_RESET_PC + 32'(fetched * 4));
                imem_data = program_mem[imem_addr[9:2]];
                imem_ack  = 1'b1;
                pending   = 1'b0;
                fetched++;
            end else begin
                delay = delay - 32'd1;
            end
        end
    end

    always @(negedge clock) begin
        result_t expected;
        if (!reset && retire.valid) begin
            expected = expect_result(`RV_RESET_PC + 32'(retired * 4), program_mem[retired[7:0]]);
            compare("retire.pc", retire.pc, expected.pc);
            compare("retire.rd", 32'(retire.rd), 32'(expected.rd));
            compare("retire.value", retire.value, expected.value);
            if (expected.rd != '0) begin
                model_regs[expected.rd] = expected.value;
            end
            retired++;
            if (retired == PROG_LEN) begin
                $display("ALL TESTS PASSED");
                $finish;
            end
        end
    end

    always @(negedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: retirement stalled after %0d of %0d instructions",
                     retired, PROG_LEN);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

endmodule

// File: rv_core.f
+incdir+.
rv_core_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core

output=$(./obj_dir/Vtb_rv_core 2>&1) || true
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi
